//--- rtl/frv_pkg.sv
// Shared definitions for the reduced RV32 integer pipeline.
// Data widths, micro-op and fetch FSM encodings, stage payload structs.

`default_nettype none

package frv_pkg;

    localparam int XLEN   = 32;                    // Data and address width
    localparam int REG_AW = 5;                     // GPR address width

    // ALU micro-ops carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD,                                   // Also used by LUI
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                                   // Signed compare
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    // Instruction fetch FSM
    typedef enum logic {
        FETCH_REQ,                                 // Request held until grant
        FETCH_WAIT                                 // Waiting for the response
    } fetch_state_t;

    // ----------------------------------------------------------------------
    // Stage payloads

    typedef struct packed {
        logic [XLEN-1:0]   pc;                     // Address of the word
        logic [XLEN-1:0]   instr;                  // Raw instruction word
    } fetch_out_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;                     // Destination register
        logic              rd_wen;                 // Write rd on retire
        logic [XLEN-1:0]   opr_a;                  // Forwarded rs1 or zero
        logic [XLEN-1:0]   opr_b;                  // rs2 or immediate
        alu_op_t           uop;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
    } decode_out_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              rd_wen;
        logic [XLEN-1:0]   wdata;                  // ALU result
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
    } exec_out_t;

    // One forwarding source, valid only when a write is pending
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } fwd_src_t;

endpackage

`default_nettype wire

//--- rtl/frv_gprs.sv
// General purpose register file.
// 31 writable registers with two asynchronous read ports, x0 reads zero.

`timescale 1ns/10ps
`default_nettype none

module frv_gprs import frv_pkg::*; (
    input  logic              g_clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  logic              gpr_wen,
    input  logic [REG_AW-1:0] gpr_rd,
    input  logic [XLEN-1:0]   gpr_wdata
);

    logic [XLEN-1:0] regs [1:(1<<REG_AW)-1];     // No storage for x0

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && gpr_rd != '0) begin
            regs[gpr_rd] <= gpr_wdata;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- rtl/frv_forward.sv
// Operand forwarding.
// Resolves read-after-write hazards on both decode source registers from
// the execute result (nearest) and the writeback result.

`timescale 1ns/10ps
`default_nettype none

module frv_forward import frv_pkg::*; (
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    input  logic [XLEN-1:0]   raw_rs1,     // Register file read data
    input  logic [XLEN-1:0]   raw_rs2,
    input  fwd_src_t          fwd_s2,      // Highest priority
    input  fwd_src_t          fwd_s3,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data
);

    // Newest matching producer wins, x0 is never forwarded
    function automatic logic [XLEN-1:0] fwd_sel(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   raw,
        input fwd_src_t          near,
        input fwd_src_t          far
    );
        logic hzd_near;
        logic hzd_far;
        hzd_near = near.valid && (near.rd == addr) && (addr != '0);
        hzd_far  = far.valid  && (far.rd  == addr) && (addr != '0);
        if (hzd_near) begin
            return near.wdata;
        end else if (hzd_far) begin
            return far.wdata;
        end else begin
            return raw;
        end
    endfunction

    assign rs1_data = fwd_sel(rs1_addr, raw_rs1, fwd_s2, fwd_s3);
    assign rs2_data = fwd_sel(rs2_addr, raw_rs2, fwd_s2, fwd_s3);

endmodule

`default_nettype wire

//--- rtl/frv_pipeline_fetch.sv
// Instruction fetch stage.
// Issues one instruction memory request at a time using the req/gnt/recv
// strobes and registers each received word with its PC into stage 1.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_fetch import frv_pkg::*; #(
    parameter logic [XLEN-1:0] FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic            g_clk,
    input  logic            rst_n,
    output logic            imem_req,     // Held high until granted
    output logic [XLEN-1:0] imem_addr,
    input  logic            imem_gnt,
    input  logic            imem_recv,    // One cycle, carries imem_rdata
    input  logic [XLEN-1:0] imem_rdata,
    output logic            s1_valid,     // One cycle per fetched word
    output fetch_out_t      s1
);

    fetch_state_t    state;
    logic [XLEN-1:0] pc;                  // Address of the pending fetch
    logic            req_q;               // Registered request strobe

    wire req_done  = req_q && imem_gnt;               // Address accepted
    wire resp_done = (state == FETCH_WAIT) && imem_recv;

    assign imem_req  = req_q;
    assign imem_addr = pc;

    // ----------------------------------------------------------------------
    // Request FSM

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            state <= FETCH_REQ;
            req_q <= 1'b0;                // Rises once reset is released
            pc    <= FRV_PC_RESET_VALUE;
        end else begin
            case (state)
                FETCH_REQ: begin
                    if (req_done) begin
                        state <= FETCH_WAIT;
                        req_q <= 1'b0;
                    end else begin
                        req_q <= 1'b1;
                    end
                end
                FETCH_WAIT: begin
                    if (resp_done) begin
                        state <= FETCH_REQ;
                        req_q <= 1'b1;    // Next request straight away
                        pc    <= pc + XLEN'(4);
                    end
                end
                default: state <= FETCH_REQ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Stage 1 register

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= resp_done;
        end
    end

    always_ff @(posedge g_clk) begin
        if (resp_done) begin
            s1.pc    <= pc;               // PC before the step
            s1.instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/frv_pipeline_decode.sv
// Instruction decode stage.
// Maps the kept RV32I ALU, immediate and LUI encodings onto ALU micro-ops,
// selects register or immediate operands and registers stage 2.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_decode import frv_pkg::*; (
    input  logic              g_clk,
    input  logic              rst_n,
    input  logic              s1_valid,
    input  fetch_out_t        s1,
    output logic [REG_AW-1:0] rs1_addr,   // To register file and forwarding
    output logic [REG_AW-1:0] rs2_addr,
    input  logic [XLEN-1:0]   rs1_data,   // Forwarded source values
    input  logic [XLEN-1:0]   rs2_data,
    output logic              s2_valid,
    output decode_out_t       s2
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;   // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // Register-immediate
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    wire [6:0]        opcode = s1.instr[6:0];
    wire [2:0]        funct3 = s1.instr[14:12];
    wire [6:0]        funct7 = s1.instr[31:25];
    wire [REG_AW-1:0] rd     = s1.instr[11:7];

    wire [XLEN-1:0] imm_i = {{(XLEN-12){s1.instr[31]}}, s1.instr[31:20]};
    wire [XLEN-1:0] imm_u = {s1.instr[31:12], 12'b0};

    alu_op_t     uop;
    logic        dec_ok;                  // Supported encoding
    logic        use_imm;                 // Operand B from I immediate
    logic        is_lui;
    decode_out_t s2_d;

    assign rs1_addr = s1.instr[19:15];
    assign rs2_addr = s1.instr[24:20];

    // ----------------------------------------------------------------------
    // Opcode and funct decode

    always_comb begin
        uop     = ALU_ADD;
        dec_ok  = 1'b0;
        use_imm = 1'b0;
        is_lui  = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                case (funct3)
                    3'b000:  uop = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  uop = ALU_SLL;
                    3'b010:  uop = ALU_SLT;
                    3'b100:  uop = ALU_XOR;
                    3'b101:  uop = ALU_SRL;
                    3'b110:  uop = ALU_OR;
                    3'b111:  uop = ALU_AND;
                    default: dec_ok = 1'b0;   // SLTU
                endcase
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                dec_ok  = 1'b1;
                case (funct3)
                    3'b000:  uop = ALU_ADD;
                    3'b010:  uop = ALU_SLT;
                    3'b100:  uop = ALU_XOR;
                    3'b110:  uop = ALU_OR;
                    3'b111:  uop = ALU_AND;
                    default: dec_ok = 1'b0;   // Shift immediates, SLTIU
                endcase
            end
            OPC_LUI: begin
                is_lui = 1'b1;                // Zero plus U immediate
                dec_ok = 1'b1;
            end
            default: dec_ok = 1'b0;           // Retires with no write
        endcase
    end

    // ----------------------------------------------------------------------
    // Operand select and stage 2 register

    always_comb begin
        s2_d.rd     = rd;
        s2_d.rd_wen = dec_ok && (rd != '0);   // x0 writes dropped here
        s2_d.opr_a  = is_lui ? '0 : rs1_data;
        s2_d.opr_b  = is_lui ? imm_u : (use_imm ? imm_i : rs2_data);
        s2_d.uop    = uop;
        s2_d.pc     = s1.pc;
        s2_d.instr  = s1.instr;
    end

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        s2 <= s2_d;                           // Loads every cycle
    end

endmodule

`default_nettype wire

//--- rtl/frv_pipeline_execute.sv
// Execute stage.
// Integer ALU for the decoded micro-op. The result is offered for
// forwarding to decode and registered into stage 3.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_execute import frv_pkg::*; (
    input  logic        g_clk,
    input  logic        rst_n,
    input  logic        s2_valid,
    input  decode_out_t s2,
    output fwd_src_t    fwd_s2,           // Result of the stage 2 instruction
    output logic        s3_valid,
    output exec_out_t   s3
);

    localparam int SHW = $clog2(XLEN);    // Shift amount width

    logic [XLEN-1:0] alu_result;
    wire  [SHW-1:0]  shamt = s2.opr_b[SHW-1:0];
    wire             lt    = $signed(s2.opr_a) < $signed(s2.opr_b);

    always_comb begin
        case (s2.uop)
            ALU_ADD: alu_result = s2.opr_a + s2.opr_b;
            ALU_SUB: alu_result = s2.opr_a - s2.opr_b;
            ALU_AND: alu_result = s2.opr_a & s2.opr_b;
            ALU_OR:  alu_result = s2.opr_a | s2.opr_b;
            ALU_XOR: alu_result = s2.opr_a ^ s2.opr_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLL: alu_result = s2.opr_a << shamt;
            ALU_SRL: alu_result = s2.opr_a >> shamt;
            default: alu_result = '0;
        endcase
    end

    assign fwd_s2.valid = s2_valid && s2.rd_wen;
    assign fwd_s2.rd    = s2.rd;
    assign fwd_s2.wdata = alu_result;

    // ----------------------------------------------------------------------
    // Stage 3 register

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            s3_valid <= 1'b0;
        end else begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        s3.rd     <= s2.rd;
        s3.rd_wen <= s2.rd_wen;
        s3.wdata  <= alu_result;
        s3.pc     <= s2.pc;
        s3.instr  <= s2.instr;
    end

endmodule

`default_nettype wire

//--- rtl/frv_pipeline_writeback.sv
// Writeback stage.
// Commits stage 3 results to the register file and registers the
// retirement trace at the same clock edge.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_writeback import frv_pkg::*; (
    input  logic              g_clk,
    input  logic              rst_n,
    input  logic              s3_valid,
    input  exec_out_t         s3,
    output fwd_src_t          fwd_s3,     // Pending register write
    output logic              gpr_wen,
    output logic [REG_AW-1:0] gpr_rd,
    output logic [XLEN-1:0]   gpr_wdata,
    output logic              trs_valid,
    output logic [XLEN-1:0]   trs_pc,
    output logic [XLEN-1:0]   trs_instr,
    output logic              trs_rd_wen,
    output logic [REG_AW-1:0] trs_rd,
    output logic [XLEN-1:0]   trs_wdata
);

    assign gpr_wen   = s3_valid && s3.rd_wen;    // Never stalls
    assign gpr_rd    = s3.rd;
    assign gpr_wdata = s3.wdata;

    assign fwd_s3.valid = gpr_wen;
    assign fwd_s3.rd    = s3.rd;
    assign fwd_s3.wdata = s3.wdata;

    // ----------------------------------------------------------------------
    // Retirement trace

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            trs_valid  <= 1'b0;
            trs_rd_wen <= 1'b0;
        end else begin
            trs_valid  <= s3_valid;
            trs_rd_wen <= gpr_wen;
        end
    end

    always_ff @(posedge g_clk) begin
        trs_pc    <= s3.pc;
        trs_instr <= s3.instr;
        trs_rd    <= s3.rd;
        trs_wdata <= s3.wdata;
    end

endmodule

`default_nettype wire

//--- rtl/frv_pipeline.sv
// Top level of the reduced RV32 pipeline.
// Fetch, decode, execute and writeback stages around the register file
// and the operand forwarding network.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline import frv_pkg::*; #(
    parameter logic [XLEN-1:0] FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic              g_clk,       // Global clock
    input  logic              rst_n,       // Synchronous reset
    output logic              imem_req,    // Fetch request
    output logic [XLEN-1:0]   imem_addr,   // Fetch address
    input  logic              imem_gnt,    // Request accepted
    input  logic              imem_recv,   // Response strobe
    input  logic [XLEN-1:0]   imem_rdata,  // Instruction word
    output logic              trs_valid,   // Instruction retired
    output logic [XLEN-1:0]   trs_pc,
    output logic [XLEN-1:0]   trs_instr,
    output logic              trs_rd_wen,
    output logic [REG_AW-1:0] trs_rd,
    output logic [XLEN-1:0]   trs_wdata
);

    logic              s1_valid;
    fetch_out_t        s1;
    logic              s2_valid;
    decode_out_t       s2;
    logic              s3_valid;
    exec_out_t         s3;

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   raw_rs1;        // Straight from the register file
    logic [XLEN-1:0]   raw_rs2;
    logic [XLEN-1:0]   rs1_data;       // After forwarding
    logic [XLEN-1:0]   rs2_data;

    fwd_src_t          fwd_s2;         // Execute result
    fwd_src_t          fwd_s3;         // Result being written back

    logic              gpr_wen;
    logic [REG_AW-1:0] gpr_rd;
    logic [XLEN-1:0]   gpr_wdata;

    // ----------------------------------------------------------------------
    // Stages

    frv_pipeline_fetch #(
        .FRV_PC_RESET_VALUE(FRV_PC_RESET_VALUE)
    ) i_pipeline_s0_fetch (
        .g_clk, .rst_n,
        .imem_req, .imem_addr, .imem_gnt, .imem_recv, .imem_rdata,
        .s1_valid, .s1
    );

    frv_pipeline_decode i_pipeline_s1_decode (
        .g_clk, .rst_n,
        .s1_valid, .s1,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .s2_valid, .s2
    );

    frv_pipeline_execute i_pipeline_s2_execute (
        .g_clk, .rst_n,
        .s2_valid, .s2,
        .fwd_s2, .s3_valid, .s3
    );

    frv_pipeline_writeback i_pipeline_s3_writeback (
        .g_clk, .rst_n,
        .s3_valid, .s3,
        .fwd_s3, .gpr_wen, .gpr_rd, .gpr_wdata,
        .trs_valid, .trs_pc, .trs_instr, .trs_rd_wen, .trs_rd, .trs_wdata
    );

    // ----------------------------------------------------------------------
    // Register file and hazard resolution

    frv_gprs i_gprs (
        .g_clk, .rst_n,
        .rs1_addr, .rs2_addr,
        .rs1_data (raw_rs1),
        .rs2_data (raw_rs2),
        .gpr_wen, .gpr_rd, .gpr_wdata
    );

    frv_forward i_forward (
        .rs1_addr, .rs2_addr, .raw_rs1, .raw_rs2,
        .fwd_s2, .fwd_s3,
        .rs1_data, .rs2_data
    );

endmodule

`default_nettype wire

//--- tb/frv_pipeline_props.sv
// Interface properties of the pipeline top level.
// Instruction memory handshake and retirement trace sanity.

`timescale 1ns/10ps
`default_nettype none

module frv_pipeline_props import frv_pkg::*; (
    input logic              g_clk,
    input logic              rst_n,
    input logic              imem_req,
    input logic              imem_gnt,
    input logic              imem_recv,
    input logic              trs_valid,
    input logic              trs_rd_wen,
    input logic [REG_AW-1:0] trs_rd
);

    logic gnt_pending;                       // Granted, no response yet

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            gnt_pending <= 1'b0;
        end else if (imem_req && imem_gnt) begin
            gnt_pending <= 1'b1;
        end else if (imem_recv) begin
            gnt_pending <= 1'b0;
        end
    end

    req_held: assert property (@(posedge g_clk) disable iff (!rst_n)
        imem_req && !imem_gnt |=> imem_req)
        else $error("imem_req dropped before grant");

    recv_granted: assert property (@(posedge g_clk) disable iff (!rst_n)
        imem_recv |-> gnt_pending)
        else $error("imem_recv without a granted request");

    trs_known: assert property (@(posedge g_clk) disable iff (!rst_n)
        !$isunknown(trs_valid))
        else $error("trs_valid is unknown");

    rd_nonzero: assert property (@(posedge g_clk) disable iff (!rst_n)
        trs_valid && trs_rd_wen |-> trs_rd != '0)
        else $error("register write retired to x0");

endmodule

bind frv_pipeline frv_pipeline_props i_props (
    .g_clk(g_clk), .rst_n(rst_n),
    .imem_req(imem_req), .imem_gnt(imem_gnt), .imem_recv(imem_recv),
    .trs_valid(trs_valid), .trs_rd_wen(trs_rd_wen), .trs_rd(trs_rd)
);

`default_nettype wire

//--- tb/tb_frv_pipeline.sv
// Testbench for the reduced RV32 pipeline.
// Serves instruction memory from the pattern file and checks every
// retirement, first with zero-wait memory, then with random stalls.

`timescale 1ns/10ps
`default_nettype none

module tb_frv_pipeline;

    localparam logic [31:0] RESET_PC       = 32'h0000_1000;
    localparam int          MAX_PAT        = 64;
    localparam int          REQ_TIMEOUT    = 20;        // Cycles
    localparam int          RETIRE_TIMEOUT = 2000;

    logic        g_clk;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_gnt;
    logic        imem_recv;
    logic [31:0] imem_rdata;
    logic        trs_valid;
    logic [31:0] trs_pc;
    logic [31:0] trs_instr;
    logic        trs_rd_wen;
    logic [4:0]  trs_rd;
    logic [31:0] trs_wdata;

    logic [31:0] pat_instr [MAX_PAT];       // Program, one word per retirement
    logic        pat_wen   [MAX_PAT];
    logic [4:0]  pat_rd    [MAX_PAT];
    logic [31:0] pat_wdata [MAX_PAT];
    int          pat_n;

    // ----------------------------------------------------------------------
    // Memory model state
    logic        stall_mode;
    logic        granted;                   // Handshake at the coming edge
    logic        pending;                   // Response still owed
    logic        req_seen;
    int          gnt_delay;
    int          resp_delay;
    logic [31:0] pend_addr;
    logic [31:0] rnd_state;

    frv_pipeline #(
        .FRV_PC_RESET_VALUE(RESET_PC)
    ) uut (
        .g_clk, .rst_n,
        .imem_req, .imem_addr, .imem_gnt, .imem_recv, .imem_rdata,
        .trs_valid, .trs_pc, .trs_instr, .trs_rd_wen, .trs_rd, .trs_wdata
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;          // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Program words by index, unused space holds undecoded FENCE words
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (addr >= RESET_PC && idx < pat_n) begin
            return pat_instr[idx[5:0]];
        end
        return {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'b0001111};
    endfunction

    task automatic draw_delay(output int d);
        if (stall_mode) begin
            rnd_state = xorshift32(rnd_state);
            d = {30'b0, rnd_state[1:0]};     // 0 to 3 cycles
        end else begin
            d = 0;
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    // One memory cycle, inputs change 2 ns after the edge
    task automatic serve_imem();
        imem_gnt  = 1'b0;
        imem_recv = 1'b0;
        if (!rst_n) begin
            granted  = 1'b0;
            pending  = 1'b0;
            req_seen = 1'b0;
        end else begin
            if (granted) begin
                granted = 1'b0;
                pending = 1'b1;
                draw_delay(resp_delay);
            end
            if (pending) begin
                if (resp_delay == 0) begin
                    imem_recv  = 1'b1;       // Single cycle strobe
                    imem_rdata = fetch_word(pend_addr);
                    pending    = 1'b0;
                end else begin
                    resp_delay--;
                end
            end else if (imem_req) begin
                if (!req_seen) begin
                    req_seen = 1'b1;
                    draw_delay(gnt_delay);
                end
                if (gnt_delay == 0) begin
                    imem_gnt  = 1'b1;
                    granted   = 1'b1;
                    pend_addr = imem_addr;
                    req_seen  = 1'b0;
                end else begin
                    gnt_delay--;
                end
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge g_clk);
        #2;
        serve_imem();
    endtask

    task automatic load_patterns();
        int          fd;
        int          cnt;
        int          f_wen;
        int          f_rd;
        logic [31:0] f_instr;
        logic [31:0] f_wdata;
        string       line;
        fd = $fopen("tb/frv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file tb/frv_patterns.txt");
            $display("Simulation FAILED");
            $fatal(1, "no patterns");
        end
        cnt   = -1;
        pat_n = 0;
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "count %d", cnt) == 1) begin
                continue;                    // Retirement count line
            end
            if ($sscanf(line, "%h %d %d %h", f_instr, f_wen, f_rd,
                        f_wdata) == 4 && pat_n < MAX_PAT) begin
                pat_instr[pat_n[5:0]] = f_instr;
                pat_wen[pat_n[5:0]]   = f_wen[0];
                pat_rd[pat_n[5:0]]    = f_rd[4:0];
                pat_wdata[pat_n[5:0]] = f_wdata;
                pat_n++;
            end
        end
        $fclose(fd);
        if (cnt != pat_n || pat_n == 0) begin
            $display("Pattern file gives count %0d but holds %0d words", cnt, pat_n);
            $display("Simulation FAILED");
            $fatal(1, "bad pattern file");
        end
    endtask

    task automatic check_retire(input int n);
        check_eq($sformatf("retire %0d trs_pc", n), trs_pc, RESET_PC + 32'(4 * n));
        check_eq($sformatf("retire %0d trs_instr", n), trs_instr, pat_instr[n[5:0]]);
        check_eq($sformatf("retire %0d trs_rd_wen", n), {31'b0, trs_rd_wen},
                 {31'b0, pat_wen[n[5:0]]});
        check_eq($sformatf("retire %0d trs_rd", n), {27'b0, trs_rd},
                 {27'b0, pat_rd[n[5:0]]});
        if (pat_wen[n[5:0]]) begin
            check_eq($sformatf("retire %0d trs_wdata", n), trs_wdata, pat_wdata[n[5:0]]);
        end
    endtask

    task automatic run_pass(input logic stall);
        int cycles;
        int retired;
        stall_mode = stall;
        rst_n      = 1'b0;
        repeat (5) begin
            step_cycle();
            check_eq("imem_req in reset", {31'b0, imem_req}, 32'd0);
            check_eq("trs_valid in reset", {31'b0, trs_valid}, 32'd0);
        end
        rst_n  = 1'b1;
        cycles = 0;
        while (imem_req !== 1'b1) begin
            step_cycle();
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                report_timeout("the first fetch request");
            end
        end
        check_eq("cycles to first request", cycles, 32'd1);
        check_eq("first imem_addr", imem_addr, RESET_PC);
        retired = 0;
        cycles  = 0;
        while (retired < pat_n) begin
            step_cycle();
            if (trs_valid === 1'b1) begin
                check_retire(retired);
                retired++;
            end
            cycles++;
            if (cycles > RETIRE_TIMEOUT) begin
                report_timeout($sformatf("retirement %0d", retired));
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_gnt   = 1'b0;
        imem_recv  = 1'b0;
        imem_rdata = '0;
        rnd_state  = 32'd71;
        granted    = 1'b0;
        pending    = 1'b0;
        req_seen   = 1'b0;
        gnt_delay  = 0;
        resp_delay = 0;
        pend_addr  = '0;
        load_patterns();
        run_pass(1'b0);                      // Zero-wait memory
        run_pass(1'b1);                      // Random grant and response delays
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/frv_patterns.txt
# columns: instruction word (hex), rd write flag, rd (decimal), write data (hex)
# one line per retirement in program order, count is the retirements per pass
count 20
00500093 1 1 00000005
00308113 1 2 00000008
002081b3 1 3 0000000d
40118233 1 4 00000008
fff00293 1 5 ffffffff
0012a333 1 6 00000001
002093b3 1 7 00000500
0012d433 1 8 07ffffff
0083c4b3 1 9 07fffaff
00626533 1 10 00000009
00a4f5b3 1 11 00000009
12345637 1 12 12345000
0ff64693 1 13 123450ff
7006e713 1 14 123457ff
ff077793 1 15 123457f0
0002a813 1 16 00000001
00708013 0 0 00000000
001008b3 1 17 00000005
0020b933 0 18 00000000
011909b3 1 19 00000005

//--- src.f
rtl/frv_pkg.sv
rtl/frv_gprs.sv
rtl/frv_forward.sv
rtl/frv_pipeline_fetch.sv
rtl/frv_pipeline_decode.sv
rtl/frv_pipeline_execute.sv
rtl/frv_pipeline_writeback.sv
rtl/frv_pipeline.sv
tb/frv_pipeline_props.sv
tb/tb_frv_pipeline.sv

//--- Makefile
# Verilator flow for the reduced RV32 pipeline

VERILATOR ?= verilator
TOP       ?= tb_frv_pipeline
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
